// File: fpu_mul_pkg.sv
/* binary32 field widths, bias and the structs passed between the multiplier stages.
   imported by every stage of the single-precision multiply path */
`default_nettype none

package fpu_mul_pkg;

  // binary32 field layout
  localparam int FP_WIDTH   = 32;
  localparam int FRAC_WIDTH = 23;   // stored fraction, hidden bit excluded
  localparam int EXP_WIDTH  = 8;
  localparam int EXP_BIAS   = 127;

  // exponent sum carries two extra bits so that it can
  // go negative or overflow past 255 without wrapping
  localparam int SUM_WIDTH  = EXP_WIDTH + 2;

  // canonical quiet NaN returned for every invalid product
  localparam logic [FP_WIDTH-1:0] QNAN = 32'h7FC0_0000;

  // operand pair as captured by the handshake
  typedef struct packed {
    logic [FP_WIDTH-1:0] opa;
    logic [FP_WIDTH-1:0] opb;
  } fp_pair_t;

  // pre-normalization results
  typedef struct packed {
    logic [SUM_WIDTH-1:0]  exp_10;     // two's complement, bias removed once
    logic [FRAC_WIDTH:0]   fracta_24;  // hidden bit plus fraction
    logic [FRAC_WIDTH:0]   fractb_24;
  } pre_norm_t;

  // result sign and special-case class
  // at most one of is_nan, is_inf and is_zero is set
  typedef struct packed {
    logic sign;     // xor of operand signs
    logic is_nan;   // nan operand, or inf times zero
    logic is_inf;
    logic is_zero;
  } class_t;

endpackage

`default_nettype wire

// File: fpu_pre_norm_mul.sv
/* pre-normalization for the multiply path. registers the biased exponent sum and
   forms both 24-bit significands combinationally from the held operand pair */
`default_nettype none

module fpu_pre_norm_mul (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  fpu_mul_pkg::fp_pair_t  ops_i,
  output fpu_mul_pkg::pre_norm_t pre_o
);
  import fpu_mul_pkg::*;

  logic [EXP_WIDTH-1:0] exp_a;
  logic [EXP_WIDTH-1:0] exp_b;
  logic [SUM_WIDTH-1:0] exp_sum_d;
  logic [SUM_WIDTH-1:0] exp_10_q;

  // denormals behave as exponent 1 with no hidden bit
  function automatic logic [SUM_WIDTH-1:0] eff_exp(input logic [EXP_WIDTH-1:0] e);
    logic [SUM_WIDTH-1:0] r;
    r = {{(SUM_WIDTH-EXP_WIDTH){1'b0}}, e};
    if (e == '0)
    begin
      r = SUM_WIDTH'(1);
    end
    return r;
  endfunction

  function automatic logic [FRAC_WIDTH:0] sig24(input logic [FP_WIDTH-1:0] op);
    return {(op[FRAC_WIDTH +: EXP_WIDTH] != '0), op[FRAC_WIDTH-1:0]};
  endfunction

  assign exp_a = ops_i.opa[FRAC_WIDTH +: EXP_WIDTH];
  assign exp_b = ops_i.opb[FRAC_WIDTH +: EXP_WIDTH];

  // ea + eb - bias, may go negative for tiny products
  assign exp_sum_d = eff_exp(exp_a) + eff_exp(exp_b) - SUM_WIDTH'(EXP_BIAS);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      exp_10_q <= '0;
    else
      exp_10_q <= exp_sum_d;
  end

  always_comb
  begin
    pre_o.exp_10    = exp_10_q;
    pre_o.fracta_24 = sig24(ops_i.opa);  // no latency, operands are held upstream
    pre_o.fractb_24 = sig24(ops_i.opb);
  end

endmodule

`default_nettype wire

// File: fpu_mul_class.sv
/* sign and special-operand classification for the multiply path.
   runs beside pre-normalization and registers one class_t per operand pair */
`default_nettype none

module fpu_mul_class (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  fpu_mul_pkg::fp_pair_t ops_i,
  output fpu_mul_pkg::class_t   cls_o
);
  import fpu_mul_pkg::*;

  typedef struct packed {
    logic nan;
    logic inf;
    logic zero;
  } op_kind_t;

  op_kind_t kind_a;
  op_kind_t kind_b;
  class_t   cls_d;

  // decode a single binary32 operand from its fields
  function automatic op_kind_t decode(input logic [FP_WIDTH-1:0] op);
    logic     exp_ones;
    logic     exp_zero;
    logic     frac_zero;
    op_kind_t k;
    exp_ones  = &op[FRAC_WIDTH +: EXP_WIDTH];
    exp_zero  = ~|op[FRAC_WIDTH +: EXP_WIDTH];
    frac_zero = ~|op[FRAC_WIDTH-1:0];
    k.nan     = exp_ones & ~frac_zero;
    k.inf     = exp_ones & frac_zero;
    k.zero    = exp_zero & frac_zero;   // denormals are not zero
    return k;
  endfunction

  assign kind_a = decode(ops_i.opa);
  assign kind_b = decode(ops_i.opb);

  always_comb
  begin
    cls_d.sign   = ops_i.opa[FP_WIDTH-1] ^ ops_i.opb[FP_WIDTH-1];
    cls_d.is_nan = kind_a.nan | kind_b.nan
                 | (kind_a.inf & kind_b.zero)
                 | (kind_b.inf & kind_a.zero);      // inf * 0 is invalid
    cls_d.is_inf  = (kind_a.inf | kind_b.inf) & ~cls_d.is_nan;
    cls_d.is_zero = (kind_a.zero | kind_b.zero) & ~cls_d.is_nan & ~cls_d.is_inf;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      cls_o <= '0;
    else
      cls_o <= cls_d;
  end

endmodule

`default_nettype wire

// File: fpu_post_norm_mul.sv
/* post-normalization for the multiply path. multiplies the significands, normalizes,
   truncates and picks the final registered result from the class and exponent range */
`default_nettype none

module fpu_post_norm_mul (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  fpu_mul_pkg::pre_norm_t           pre_i,
  input  fpu_mul_pkg::class_t              cls_i,
  output logic [fpu_mul_pkg::FP_WIDTH-1:0] result_o
);
  import fpu_mul_pkg::*;

  localparam int SIG_W   = FRAC_WIDTH + 1;
  localparam int PROD_W  = 2 * SIG_W;          // 48-bit significand product
  localparam int LZ_W    = $clog2(PROD_W);
  localparam int ADJ_W   = SUM_WIDTH + 2;      // room for +1 and the shift count
  localparam int EXP_MAX = (1 << EXP_WIDTH) - 1;

  logic [PROD_W-1:0]       prod;
  logic [PROD_W-1:0]       prod_norm;
  logic [LZ_W-1:0]         lz;
  logic signed [ADJ_W-1:0] exp_ext;
  logic signed [ADJ_W-1:0] exp_adj;
  logic [FRAC_WIDTH-1:0]   frac_trunc;
  logic [FP_WIDTH-1:0]     result_d;

  // leading zeros above the highest set bit of the lower 47 product bits
  function automatic logic [LZ_W-1:0] count_lz(input logic [PROD_W-2:0] v);
    logic [LZ_W-1:0] cnt;
    cnt = LZ_W'(PROD_W - 1);   // all zero
    for (int i = 0; i < PROD_W - 1; i++)
    begin
      if (v[i])
      begin
        cnt = LZ_W'(PROD_W - 2 - i);
      end
    end
    return cnt;
  endfunction

  always_comb
  begin
    prod      = pre_i.fracta_24 * pre_i.fractb_24;
    exp_ext   = {{(ADJ_W-SUM_WIDTH){pre_i.exp_10[SUM_WIDTH-1]}}, pre_i.exp_10};
    lz        = count_lz(prod[PROD_W-2:0]);
    prod_norm = prod << lz;   // leading one lands on bit 46

    if (prod[PROD_W-1])
    begin
      // product in [2,4), one bit right and exponent up by one
      exp_adj    = exp_ext + {{(ADJ_W-1){1'b0}}, 1'b1};
      frac_trunc = prod[PROD_W-2 -: FRAC_WIDTH];
    end
    else
    begin
      exp_adj    = exp_ext - {{(ADJ_W-LZ_W){1'b0}}, lz};
      frac_trunc = prod_norm[PROD_W-3 -: FRAC_WIDTH];  // bits below the leading one
    end
  end

  // NaN first, then infinity, then zero
  always_comb
  begin
    if (cls_i.is_nan)
    begin
      result_d = QNAN;
    end
    else if (cls_i.is_inf || exp_adj >= EXP_MAX)
    begin
      result_d = {cls_i.sign, {EXP_WIDTH{1'b1}}, {FRAC_WIDTH{1'b0}}};
    end
    else if (cls_i.is_zero || prod == '0 || exp_adj <= 0)
    begin
      result_d = {cls_i.sign, {(FP_WIDTH-1){1'b0}}};   // underflow flushes to zero
    end
    else
    begin
      result_d = {cls_i.sign, exp_adj[EXP_WIDTH-1:0], frac_trunc};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      result_o <= '0;
    else
      result_o <= result_d;
  end

endmodule

`default_nettype wire

// File: fpu_mul.sv
/* single-precision multiplier top level with a four-phase req/ack handshake.
   captures the operands, runs the three stages and acknowledges three cycles later */
`default_nettype none

module fpu_mul (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             req_i,
  input  logic [fpu_mul_pkg::FP_WIDTH-1:0] opa_i,
  input  logic [fpu_mul_pkg::FP_WIDTH-1:0] opb_i,
  output logic                             ack_o,
  output logic [fpu_mul_pkg::FP_WIDTH-1:0] result_o
);
  import fpu_mul_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_ACK
  } state_e;

  state_e    state_q;
  logic [1:0] vld_q;     // valid through pre/class then post
  fp_pair_t  ops_q;
  pre_norm_t pre;
  class_t    cls;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q <= ST_IDLE;
      vld_q   <= '0;
      ops_q   <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (req_i)
          begin
            ops_q.opa <= opa_i;   // held until the next request
            ops_q.opb <= opb_i;
            vld_q     <= '0;
            state_q   <= ST_BUSY;
          end
        end
        ST_BUSY:
        begin
          vld_q <= {vld_q[0], 1'b1};
          if (vld_q[1])
            state_q <= ST_ACK;   // result_o registered one cycle earlier
        end
        ST_ACK:
        begin
          if (!req_i)
            state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign ack_o = (state_q == ST_ACK);

  fpu_pre_norm_mul u_pre_norm (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .ops_i (ops_q),
    .pre_o (pre)
  );

  fpu_mul_class u_class (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .ops_i (ops_q),
    .cls_o (cls)
  );

  fpu_post_norm_mul u_post_norm (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .pre_i    (pre),
    .cls_i    (cls),
    .result_o (result_o)
  );

endmodule

`default_nettype wire

// File: fpu_mul_checker.sv
/* concurrent assertions on the pre-normalization stage, bound into every
   fpu_pre_norm_mul instance of the multiplier */
`default_nettype none

module fpu_pre_norm_mul_checker (
  input logic                   clk_i,
  input logic                   rst_i,
  input fpu_mul_pkg::fp_pair_t  ops_i,
  input fpu_mul_pkg::pre_norm_t pre_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import fpu_mul_pkg::*;

  logic [EXP_WIDTH-1:0] exp_a;
  logic [EXP_WIDTH-1:0] exp_b;
  logic [SUM_WIDTH-1:0] eff_a;
  logic [SUM_WIDTH-1:0] eff_b;
  logic [SUM_WIDTH-1:0] exp_sum_ref;

  assign exp_a = ops_i.opa[FRAC_WIDTH +: EXP_WIDTH];
  assign exp_b = ops_i.opb[FRAC_WIDTH +: EXP_WIDTH];
  assign eff_a = (exp_a == '0) ? SUM_WIDTH'(1) : {2'b00, exp_a};   // denormal as exponent 1
  assign eff_b = (exp_b == '0) ? SUM_WIDTH'(1) : {2'b00, exp_b};
  assign exp_sum_ref = eff_a + eff_b - SUM_WIDTH'(EXP_BIAS);

  // registered sum follows the operands by one cycle
  exp_sum_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> pre_i.exp_10 == $past(exp_sum_ref))
    else $error("exp_10 is not ea + eb - bias of the previous cycle");

  hidden_bit_a: assert property (@(posedge clk_i) disable iff (rst_i)
    pre_i.fracta_24[FRAC_WIDTH] == (exp_a != '0) && pre_i.fractb_24[FRAC_WIDTH] == (exp_b != '0))
    else $error("hidden bit does not match the exponent field");

  frac_pass_a: assert property (@(posedge clk_i) disable iff (rst_i)
    pre_i.fracta_24[FRAC_WIDTH-1:0] == ops_i.opa[FRAC_WIDTH-1:0]
    && pre_i.fractb_24[FRAC_WIDTH-1:0] == ops_i.opb[FRAC_WIDTH-1:0])
    else $error("stored fraction not passed through");

  // held operands keep the registered sum still
  exp_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $stable(ops_i) && !$past(rst_i) |=> $stable(pre_i.exp_10))
    else $error("exp_10 changed while the operands were held");

endmodule

bind fpu_pre_norm_mul fpu_pre_norm_mul_checker u_pre_norm_checker (
  .clk_i (clk_i),
  .rst_i (rst_i),
  .ops_i (ops_i),
  .pre_i (pre_o)
);

`default_nettype wire

// File: tb_fpu_mul.sv
/* testbench for the fpu_mul multiplier. random binary32 operands go through the
   req/ack handshake and every product is checked against a field-level model */
`default_nettype none

module tb_fpu_mul;
  timeunit 1ns;
  timeprecision 100ps;
  import fpu_mul_pkg::*;

  localparam int NUM_TXN        = 2000;
  localparam int RESET_CYCLES   = 10;
  localparam int TXN_CYCLES     = 12;   // a transaction averages about 11 cycles
  localparam int TIMEOUT_CYCLES = NUM_TXN * TXN_CYCLES + RESET_CYCLES;
  localparam int ACK_LATENCY    = 3;
  localparam int ACK_WAIT_MAX   = 16;
  localparam int SEED           = 32'hae74;

  logic                clk;
  logic                rst;
  logic                req;
  logic [FP_WIDTH-1:0] opa;
  logic [FP_WIDTH-1:0] opb;
  logic                ack;
  logic [FP_WIDTH-1:0] result;
  int                  cycle_cnt = 0;

  fpu_mul u_fpu_mul (
    .clk_i    (clk),
    .rst_i    (rst),
    .req_i    (req),
    .opa_i    (opa),
    .opb_i    (opb),
    .ack_o    (ack),
    .result_o (result)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // exponent classes weighted so zero, inf, nan, denormal and overflow all show up
  function automatic logic [31:0] rand_operand();
    logic [7:0]  e;
    logic [22:0] f;
    int unsigned pick;
    pick = $urandom_range(99);
    if (pick < 15)
      e = 8'd0;
    else if (pick < 25)
      e = 8'd255;
    else if (pick < 40)
      e = 8'($urandom_range(10, 1));
    else if (pick < 55)
      e = 8'($urandom_range(254, 200));   // large pairs overflow
    else if (pick < 85)
      e = 8'($urandom_range(145, 110));   // near the bias
    else
      e = 8'($urandom);
    pick = $urandom_range(99);
    if (pick < 20)
      f = '0;
    else if (pick < 40)
      f = 23'($urandom) >> $urandom_range(22);   // short fractions, deep denormals
    else
      f = 23'($urandom);
    return {1'($urandom), e, f};
  endfunction

  // reference product with truncation and flushed denormal results
  function automatic logic [31:0] model_mul(input logic [31:0] a, input logic [31:0] b);
    int          ea;
    int          eb;
    int          exp_r;
    int          msb;
    logic [22:0] fa;
    logic [22:0] fb;
    logic [22:0] frac;
    logic        sign;
    logic        nan_a;
    logic        nan_b;
    logic        inf_a;
    logic        inf_b;
    logic        zero_a;
    logic        zero_b;
    logic [47:0] prod;
    logic [47:0] norm;
    ea     = int'(a[30:23]);
    eb     = int'(b[30:23]);
    fa     = a[22:0];
    fb     = b[22:0];
    sign   = a[31] ^ b[31];
    nan_a  = (ea == 255) && (fa != 0);
    nan_b  = (eb == 255) && (fb != 0);
    inf_a  = (ea == 255) && (fa == 0);
    inf_b  = (eb == 255) && (fb == 0);
    zero_a = (ea == 0) && (fa == 0);
    zero_b = (eb == 0) && (fb == 0);
    if (nan_a || nan_b || (inf_a && zero_b) || (inf_b && zero_a))
      return 32'h7FC0_0000;
    if (inf_a || inf_b)
      return {sign, 8'hFF, 23'd0};
    if (zero_a || zero_b)
      return {sign, 31'd0};
    // a denormal counts as exponent 1 with no hidden one
    prod  = 48'({(ea != 0), fa}) * 48'({(eb != 0), fb});
    exp_r = (ea == 0 ? 1 : ea) + (eb == 0 ? 1 : eb) - 127;
    if (prod == 0)
      return {sign, 31'd0};
    msb = 47;
    while (!prod[msb])
      msb--;
    if (msb == 47)
    begin
      exp_r = exp_r + 1;       // product in [2,4)
      frac  = prod[46:24];
    end
    else
    begin
      exp_r = exp_r - (46 - msb);
      norm  = prod << (46 - msb);
      frac  = norm[45:23];
    end
    if (exp_r >= 255)
      return {sign, 8'hFF, 23'd0};
    if (exp_r <= 0)
      return {sign, 31'd0};
    return {sign, 8'(exp_r), frac};
  endfunction

  // one full four-phase handshake with checks on every phase
  task automatic run_txn(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] expected;
    logic [31:0] held;
    int          edges;
    int          extra;
    int          idle;
    expected = model_mul(a, b);
    extra    = $urandom_range(5);
    idle     = $urandom_range(3);
    @(posedge clk);
    #2;
    req = 1'b1;
    opa = a;
    opb = b;
    edges = 0;   // first edge counted is the capture edge
    while (!ack)
    begin
      if (edges == ACK_WAIT_MAX)
      begin
        $display("ack_o did not rise within %0d cycles of req_i", ACK_WAIT_MAX);
        $display("Test FAILED");
        $fatal(1, "no acknowledge");
      end
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    check_val("ack_o latency", 1 + ACK_LATENCY, edges);
    check_val("result_o", expected, result);
    held = result;
    repeat (extra)
    begin
      @(negedge clk);
      check_val("ack_o", 1, ack);         // requester still holds req_i
      check_val("result_o", held, result);
    end
    @(posedge clk);
    #2;
    req = 1'b0;
    opa = $urandom;   // ignored outside a request
    opb = $urandom;
    @(posedge clk);
    @(negedge clk);
    check_val("ack_o", 0, ack);
    repeat (idle)
      @(posedge clk);
  endtask

  initial
  begin
    void'($urandom(SEED));
    rst = 1'b1;
    req = 1'b0;
    opa = '0;
    opb = '0;
    repeat (RESET_CYCLES)
      @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_val("ack_o", 0, ack);
    check_val("result_o", 0, result);

    run_txn(32'h3FC0_0000, 32'h3FC0_0000);   // 1.5 * 1.5 carries into bit 47
    run_txn(32'h7F80_0000, 32'h0000_0000);   // inf * 0
    run_txn(32'hFF80_0000, 32'h3F80_0000);   // -inf * 1
    run_txn(32'h8000_0000, 32'h4049_0FDB);   // -0 * pi
    run_txn(32'h0040_0000, 32'h4B00_0000);   // denormal comes back normal
    run_txn(32'h7F00_0000, 32'h7F00_0000);   // overflow
    run_txn(32'h0080_0000, 32'h0080_0000);   // underflow
    for (int i = 0; i < NUM_TXN; i++)
      run_txn(rand_operand(), rand_operand());

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: fpu_mul.f
fpu_mul_pkg.sv
fpu_pre_norm_mul.sv
fpu_mul_class.sv
fpu_post_norm_mul.sv
fpu_mul.sv
fpu_mul_checker.sv
tb_fpu_mul.sv

// File: Makefile
# Verilator build and run for the fpu_mul testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR       ?= verilator
TOP             ?= tb_fpu_mul
FILELIST        ?= fpu_mul.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG        ?= Test OK

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up in the simulator output
run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
